// File: logic/fifoOutputStage.sv
`timescale 1ns/1ps
`default_nettype none

module fifoOutputStage
  (
    input  wire logic               ChipClock,
    input  wire logic               rstN,
    input  wire logic               rdValid,     // Response arrives this cycle.
    input  wire fifoPkg::readResp_t rdWord,
    output logic                    fetchReady,  // Room for one more read.
    output logic                    outValid,
    output fifoPkg::readResp_t      outWord,
    input  wire logic               outReady
  );

  import fifoPkg::*;

  readResp_t  slot [2];   // slot[0] is always the head.
  logic [1:0] used;       // Occupied slots, 0 to 2.
  logic [2:0] pending;    // Slots claimed once this cycle settles.

  logic push;             // Capture a response.
  logic pop;              // Output transfer.

  // --------------------------------------------------
  // Output channel.
  // --------------------------------------------------

  assign outValid = (used != 2'd0);
  assign outWord  = slot[0];        // Head is shown straight from its register.

  assign push = rdValid;
  assign pop  = outValid && outReady;

  // --------------------------------------------------
  // Fetch credit.
  // --------------------------------------------------

  // A response on rdValid is the read in flight.
  // A read issued now lands one cycle later, so count it against the slots.
  assign pending    = {1'b0, used} + {2'b00, rdValid} - {2'b00, pop};
  assign fetchReady = (pending < 3'd2);

  // --------------------------------------------------
  // Slot bookkeeping.
  // --------------------------------------------------

  always_ff @(posedge ChipClock or negedge rstN)
  begin
    if (!rstN)
    begin
      used <= 2'd0;
    end
    else
    begin
      case ({push, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;        // Push and pop cancel.
      endcase
    end
  end

  // Payload moves toward the head on a pop.
  // A new word fills the first free slot.
  always_ff @(posedge ChipClock)
  begin
    if (push && ((used == 2'd0) || ((used == 2'd1) && pop)))
    begin
      slot[0] <= rdWord;              // Straight to the head.
    end
    else if (pop)
    begin
      slot[0] <= slot[1];             // Second entry advances.
    end

    // Credit keeps a push away from two held slots.
    if (push && (used == 2'd1) && !pop)
    begin
      slot[1] <= rdWord;
    end
  end

endmodule

`default_nettype wire

// File: logic/fifoPkg.sv
`default_nettype none

package fifoPkg;

  // --------------------------------------------------
  // Sizes.
  // --------------------------------------------------
  localparam int DataWidth = 32;              // Bits in one data word.
  localparam int AdrWidth  = 5;               // Storage address bits.
  localparam int Depth     = 1 << AdrWidth;   // Storage words.

  // Storage address. Pointers wrap at Depth by overflow.
  typedef logic [AdrWidth-1:0] adr_t;

  // --------------------------------------------------
  // Word layouts.
  // --------------------------------------------------

  // Word offered on the input channel.
  typedef struct packed {
    logic [DataWidth-1:0] data;         // Payload.
    logic                 injectFault;  // Store the wrong parity bit.
  } writeReq_t;

  // Word delivered on the output channel.
  typedef struct packed {
    logic [DataWidth-1:0] data;       // Payload as read back.
    logic                 parityErr;  // Stored parity disagreed.
  } readResp_t;

  // One storage cell.
  // Even parity, so parity plus data always holds an even count of ones.
  typedef struct packed {
    logic                 parity;
    logic [DataWidth-1:0] data;
  } ramCell_t;

endpackage

`default_nettype wire

// File: logic/fifoPointers.sv
`timescale 1ns/1ps
`default_nettype none

module fifoPointers
  (
    input  wire logic          ChipClock,
    input  wire logic          rstN,
    input  wire logic          inValid,     // Source offers a word.
    output logic               inReady,     // Room left in storage.
    input  wire logic          fetchReady,  // Output stage can take a read.
    output logic               wrEnable,    // Write strobe to the array.
    output fifoPkg::adr_t      wrAddr,
    output logic               rdEnable,    // Read strobe to the array.
    output fifoPkg::adr_t      rdAddr
  );

  import fifoPkg::*;

  adr_t              wrPtr;   // Next slot to fill.
  adr_t              rdPtr;   // Oldest stored slot.
  logic [AdrWidth:0] count;   // Words held in storage, 0 to Depth.

  logic accept;               // Input transfer this cycle.
  logic fetch;                // Storage read this cycle.

  // --------------------------------------------------
  // Handshake and strobes.
  // --------------------------------------------------

  assign inReady = (count < Depth);   // Full at Depth words.
  assign accept  = inValid && inReady;

  // Fetch whenever something is stored and the stage has room.
  assign fetch   = (count != '0) && fetchReady;

  assign wrEnable = accept;   // Every accepted word is written.
  assign wrAddr   = wrPtr;
  assign rdEnable = fetch;
  assign rdAddr   = rdPtr;

  // --------------------------------------------------
  // Pointers.
  // --------------------------------------------------

  // Both wrap naturally since Depth is a power of two.
  always_ff @(posedge ChipClock or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (accept)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (fetch)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Occupancy.
  // --------------------------------------------------

  // Accept and fetch together leave the count as it was.
  always_ff @(posedge ChipClock or negedge rstN)
  begin
    if (!rstN)
    begin
      count <= '0;
    end
    else
    begin
      case ({accept, fetch})
        2'b10:   count <= count + 1'b1;   // Word in only.
        2'b01:   count <= count - 1'b1;   // Word out only.
        default: count <= count;          // Neither, or both.
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/parityFifo.sv
`timescale 1ns/1ps
`default_nettype none

module parityFifo
  (
    input  wire logic               ChipClock,
    input  wire logic               rstN,
    // Input channel.
    input  wire logic               inValid,
    output logic                    inReady,
    input  wire fifoPkg::writeReq_t inWord,
    // Output channel.
    output logic                    outValid,
    input  wire logic               outReady,
    output fifoPkg::readResp_t      outWord
  );

  import fifoPkg::*;

  logic      wrEnable;    // Array write strobe.
  adr_t      wrAddr;
  logic      rdEnable;    // Array read strobe.
  adr_t      rdAddr;
  logic      rdValid;     // Read data strobe, one cycle after rdEnable.
  readResp_t rdWord;
  logic      fetchReady;  // Output stage credit.

  // --------------------------------------------------
  // Pointers and occupancy.
  // --------------------------------------------------
  fifoPointers pointers (
    .ChipClock  (ChipClock),
    .rstN       (rstN),
    .inValid    (inValid),
    .inReady    (inReady),
    .fetchReady (fetchReady),
    .wrEnable   (wrEnable),
    .wrAddr     (wrAddr),
    .rdEnable   (rdEnable),
    .rdAddr     (rdAddr)
  );

  // --------------------------------------------------
  // Parity storage.
  // --------------------------------------------------
  parityRam ram (
    .ChipClock (ChipClock),
    .rstN      (rstN),
    .wrEnable  (wrEnable),
    .wrAddr    (wrAddr),
    .wrWord    (inWord),      // Input word goes straight in.
    .rdEnable  (rdEnable),
    .rdAddr    (rdAddr),
    .rdValid   (rdValid),
    .rdWord    (rdWord)
  );

  // --------------------------------------------------
  // Output buffering.
  // --------------------------------------------------
  fifoOutputStage outStage (
    .ChipClock  (ChipClock),
    .rstN       (rstN),
    .rdValid    (rdValid),
    .rdWord     (rdWord),
    .fetchReady (fetchReady),
    .outValid   (outValid),
    .outWord    (outWord),
    .outReady   (outReady)
  );

endmodule

`default_nettype wire

// File: logic/parityRam.sv
`timescale 1ns/1ps
`default_nettype none

module parityRam
  (
    input  wire logic               ChipClock,
    input  wire logic               rstN,
    input  wire logic               wrEnable,  // Store wrWord at wrAddr.
    input  wire fifoPkg::adr_t      wrAddr,
    input  wire fifoPkg::writeReq_t wrWord,
    input  wire logic               rdEnable,  // Fetch the word at rdAddr.
    input  wire fifoPkg::adr_t      rdAddr,
    output logic                    rdValid,   // rdWord is fresh this cycle.
    output fifoPkg::readResp_t      rdWord
  );

  import fifoPkg::*;

  ramCell_t mem [Depth];  // The storage array.

  ramCell_t writeCell;    // Cell image built from the incoming word.
  ramCell_t readCell;     // Cell currently addressed by rdAddr.
  logic     parityCalc;   // Parity recomputed over the read data.

  // --------------------------------------------------
  // Write port.
  // --------------------------------------------------

  // Even parity over the data.
  // A fault request flips it so the read check trips.
  always_comb
  begin
    writeCell.data   = wrWord.data;
    writeCell.parity = (^wrWord.data) ^ wrWord.injectFault;
  end

  // Word lands in the array on the write edge.
  always_ff @(posedge ChipClock)
  begin
    if (wrEnable)
    begin
      mem[wrAddr] <= writeCell;
    end
  end

  // --------------------------------------------------
  // Read port.
  // --------------------------------------------------

  // The FIFO never reads the slot it is writing, so no bypass is needed.
  assign readCell   = mem[rdAddr];
  assign parityCalc = ^readCell.data;

  // Strobe follows rdEnable by one cycle.
  always_ff @(posedge ChipClock or negedge rstN)
  begin
    if (!rstN)
    begin
      rdValid <= 1'b0;
    end
    else
    begin
      rdValid <= rdEnable;
    end
  end

  // Data and check result are registered together.
  // They hold between reads.
  always_ff @(posedge ChipClock)
  begin
    if (rdEnable)
    begin
      rdWord.data      <= readCell.data;
      rdWord.parityErr <= readCell.parity ^ parityCalc;  // Mismatch means a bad cell.
    end
  end

endmodule

`default_nettype wire

// File: parityFifo.f
logic/fifoPkg.sv
logic/parityRam.sv
logic/fifoPointers.sv
logic/fifoOutputStage.sv
logic/parityFifo.sv
tb/parityFifo_properties.sv
tb/parityFifoTb.sv

// File: tb/parityFifoTb.sv
`timescale 1ns/1ps
`default_nettype none

module parityFifoTb;

  import fifoPkg::*;

  localparam logic [31:0] Seed       = 32'hf7c05f8e;
  localparam int          HalfPeriod = 20;     // 40 ns clock.
  localparam int          DriveDelay = 2;      // Inputs change just after the edge.
  localparam int          StallLimit = 1000;   // Idle cycles before a wait gives up.

  logic      ChipClock;
  logic      rstN;
  logic      inValid;
  logic      inReady;
  writeReq_t inWord;
  logic      outValid;
  logic      outReady;
  readResp_t outWord;

  logic [31:0] inState;       // Generator state for the source side.
  logic [31:0] outState;      // Generator state for the sink side.
  writeReq_t   refQueue [$];  // Accepted words not yet delivered.
  logic        inFire;        // Input transfer on the coming edge.
  logic        outFire;       // Output transfer on the coming edge.
  logic        stalled;       // Some wait timed out.
  int          errors;
  int          checked;

  initial ChipClock = 1'b0;
  always #HalfPeriod ChipClock = ~ChipClock;

  parityFifo UUT (.*);

  // --------------------------------------------------
  // Helpers.
  // --------------------------------------------------

  function automatic logic [31:0] lcgStep(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // True with the given percentage. Upper bits only, the low ones cycle fast.
  function automatic logic chance(inout logic [31:0] state, input int percent);
    logic [31:0] draw;
    draw = lcgStep(state);
    return int'(draw[31:16] % 16'd100) < percent;
  endfunction

  // What the FIFO should deliver for a request.
  function automatic readResp_t expectedResp(writeReq_t req);
    readResp_t resp;
    resp.data      = req.data;
    resp.parityErr = req.injectFault;   // Only a forced bad parity is flagged.
    return resp;
  endfunction

  task automatic flagMismatch(string name, logic [31:0] want, logic [31:0] got);
    errors++;
    $display("ERROR at time %0t: %s expected %h, got %h", $time, name, want, got);
  endtask

  task automatic noteProblem(string what);
    errors++;
    $display("Failure at time %0t: %s", $time, what);
  endtask

  // Offers count words. inValid stays up until the word is taken.
  task automatic produce(input int count, input int validPct, input int faultPct);
    int taken;
    int idle;
    taken = 0;
    idle  = 0;
    while ((taken < count) && !stalled)
    begin
      @(posedge ChipClock);
      #DriveDelay;
      if (inFire)
      begin
        taken++;
        idle    = 0;
        inValid = 1'b0;    // Taken on this edge.
      end
      else
      begin
        idle++;
      end
      if (!inValid && (taken < count) && chance(inState, validPct))
      begin
        inWord.data        = lcgStep(inState);
        inWord.injectFault = chance(inState, faultPct);
        inValid            = 1'b1;
      end
      if (idle > StallLimit)
      begin
        stalled = 1'b1;
        noteProblem("input side stopped accepting words");
      end
    end
    inValid = 1'b0;
  endtask

  // Takes count words with a random ready pattern.
  task automatic consume(input int count, input int readyPct);
    int taken;
    int idle;
    taken = 0;
    idle  = 0;
    while ((taken < count) && !stalled)
    begin
      @(posedge ChipClock);
      #DriveDelay;
      if (outFire)
      begin
        taken++;
        idle = 0;
      end
      else
      begin
        idle++;
      end
      outReady = (taken < count) && chance(outState, readyPct);  // Never one too many.
      if (idle > StallLimit)
      begin
        stalled = 1'b1;
        noteProblem("output side stopped delivering words");
      end
    end
    outReady = 1'b0;
  endtask

  // --------------------------------------------------
  // Comparing process, half a cycle before each edge.
  // --------------------------------------------------
  always @(negedge ChipClock)
  begin
    readResp_t wanted;
    inFire  = rstN && inValid && inReady;
    outFire = rstN && outValid && outReady;
    if (inFire)
    begin
      refQueue.push_back(inWord);
    end
    if (outFire)
    begin
      assert (refQueue.size() != 0) else noteProblem("a word came out that was never written");
      if (refQueue.size() != 0)
      begin
        wanted = expectedResp(refQueue.pop_front());
        checked++;
        assert (outWord.data == wanted.data)
          else flagMismatch("outWord.data", wanted.data, outWord.data);
        assert (outWord.parityErr == wanted.parityErr)
          else flagMismatch("outWord.parityErr", wanted.parityErr, outWord.parityErr);
      end
    end
  end

  // --------------------------------------------------
  // Sequence.
  // --------------------------------------------------
  initial
  begin
    rstN     = 1'b0;
    inValid  = 1'b0;
    inWord   = '0;
    outReady = 1'b0;
    inFire   = 1'b0;
    outFire  = 1'b0;
    stalled  = 1'b0;
    errors   = 0;
    checked  = 0;
    inState  = Seed;
    outState = ~Seed;   // Keeps the two sides uncorrelated.
    repeat (4) @(posedge ChipClock);
    #DriveDelay rstN = 1'b1;

    @(negedge ChipClock);
    assert (!outValid) else flagMismatch("outValid", 0, outValid);
    assert (inReady) else flagMismatch("inReady", 1, inReady);

    fork    // Full flow, clean words.
      produce(200, 100, 0);
      consume(200, 100);
    join
    fork    // Some words carry a forced parity fault.
      produce(120, 100, 30);
      consume(120, 100);
    join

    if (!stalled)
    begin
      produce(Depth + 2, 100, 0);   // Sink held off the whole time.
      @(negedge ChipClock);
      assert (!inReady) else noteProblem("inReady still high after Depth+2 words");
      consume(Depth + 2, 100);
    end

    fork    // Both sides throttled.
      produce(3000, 60, 10);
      consume(3000, 60);
    join

    assert (refQueue.size() == 0) else noteProblem("accepted words were never delivered");
    $display("Words checked: %0d, errors: %0d", checked, errors);
    if (errors == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/parityFifo_properties.sv
`timescale 1ns/1ps
`default_nettype none

module parityFifo_properties
  (
    input wire logic               ChipClock,
    input wire logic               rstN,
    input wire logic               inValid,
    input wire logic               inReady,
    input wire fifoPkg::writeReq_t inWord,
    input wire logic               outValid,
    input wire logic               outReady,
    input wire fifoPkg::readResp_t outWord,
    input wire logic               rdEnable,
    input wire logic               fetchReady
  );

  // --------------------------------------------------
  // Channel rules.
  // --------------------------------------------------
  inWordHeld: assert property (@(posedge ChipClock) disable iff (!rstN)
    (inValid && !inReady) |=> $stable(inWord))
    else $error("inWord changed while waiting for inReady");

  outWordHeld: assert property (@(posedge ChipClock) disable iff (!rstN)
    (outValid && !outReady) |=> (outValid && $stable(outWord)))
    else $error("outWord changed or was withdrawn under back-pressure");

  // Reset values hold for as long as reset does.
  resetState: assert property (@(posedge ChipClock)
    !rstN |-> (!outValid && inReady))
    else $error("outValid or inReady wrong during reset");

  // A stalled head plus a read in flight fill both slots.
  // No further read until the sink takes one.
  fetchCredit: assert property (@(posedge ChipClock) disable iff (!rstN)
    (rdEnable && outValid && !outReady) ##1 !outReady |-> (!fetchReady && !rdEnable))
    else $error("read issued with no free slot in the output stage");

endmodule

bind parityFifo parityFifo_properties props (
  .ChipClock  (ChipClock),
  .rstN       (rstN),
  .inValid    (inValid),
  .inReady    (inReady),
  .inWord     (inWord),
  .outValid   (outValid),
  .outReady   (outReady),
  .outWord    (outWord),
  .rdEnable   (rdEnable),
  .fetchReady (fetchReady)
);

`default_nettype wire
